/* obj_tests.txt */
# W addr data: table write | L line: render line | P x value: expected pixel | E: read out
# all numbers hex; entry 0 8x8 y 10 x 28, entry 1 8x8 y 0d x 2c, entry 2 32x32 y 28 x f8
W 000 04
W 001 30
W 002 10
W 003 28
W 004 06
W 005 08
W 006 70
W 007 0D
W 008 2C
W 009 06
W 00A 40
W 00B 90
W 00C 28
W 00D F8
W 00E 08
L 013
P 028 35
P 029 3B
P 02A 33
P 02B 3A
P 02C 75
P 02D 78
P 02E 73
P 02F 3B
P 030 75
P 031 78
P 032 73
P 033 71
E
L 034
P 0F8 94
P 0F9 9A
P 0FA 97
P 0FB 94
P 0FC 94
P 0FD 9A
P 0FE 97
P 0FF 95
E
L 1FF
E

/* tb.f */
+incdir+.
obj_pkg.sv
obj_attr_ram.sv
obj_line_draw.sv
obj_line_buf.sv
obj_video.sv
tb_obj_video.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_obj_video -f tb.f -o sim_obj_video
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_obj_video > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0

/* tb_obj_video.sv */
`timescale 1ns/10ps
`default_nettype none

`include "obj_params.svh"

module tb_obj_video import obj_pkg::*; ();

    logic                    clk = 1'b0;
    logic                    rst = 1'b1;
    cpu_wr_t                 cpu = '0;
    logic                    start = 1'b0;
    logic                    lvbl = 1'b1;
    logic [8:0]              vrender = 9'd0;
    logic                    done;
    logic                    rom_cs;
    logic [`OBJ_ROM_AW-1:0]  rom_addr;
    logic                    rom_ok = 1'b0;
    logic [`OBJ_ROM_DW-1:0]  rom_data = '0;
    logic [7:0]              pix_addr = 8'd0;
    logic [7:0]              pix;

    int          errors = 0;
    int          cycles = 0;
    int          limit = 0;
    int          rec_kind[$];
    int          rec_a[$];
    int          rec_b[$];
    logic [7:0]  expect_pix[0:`OBJ_LINE_W-1];
    logic [15:0] lfsr = 16'd8;
    logic        waiting = 1'b0;
    logic [1:0]  wait_cnt = 2'd0;
    logic [1:0]  delay;

    obj_video obj_video_inst (
        .clk(clk), .rst(rst), .cpu(cpu), .start(start), .lvbl(lvbl),
        .vrender(vrender), .done(done), .rom_cs(rom_cs), .rom_addr(rom_addr),
        .rom_ok(rom_ok), .rom_data(rom_data), .pix_addr(pix_addr), .pix(pix)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] v);
        return v[0] ? ((v >> 1) ^ 16'hB400) : (v >> 1);
    endfunction

    // ROM model, answers after 0 to 3 extra cycles
    always @(posedge clk) begin
        if (rom_ok) begin
            rom_ok <= 1'b0;
        end else if (rom_cs && !rst) begin
            if (waiting) begin
                if (wait_cnt == 2'd0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_addr[15:0] ^ 16'h5A3C;
                    waiting  <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else begin
                delay[0] = lfsr[0];  // one step per bit taken
                lfsr     = lfsr_step(lfsr);
                delay[1] = lfsr[0];
                lfsr     = lfsr_step(lfsr);
                if (delay == 2'd0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_addr[15:0] ^ 16'h5A3C;
                end else begin
                    waiting  <= 1'b1;
                    wait_cnt <= delay - 2'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("run stopped, no result after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic write_byte(input int a, input int d);
        @(posedge clk);
        cpu.we   <= 1'b1;
        cpu.addr <= 9'(a);
        cpu.data <= 8'(d);
        @(posedge clk);
        cpu.we   <= 1'b0;
    endtask

    // start edge, then wait for the scan to end
    task automatic render_line(input int v);
        @(posedge clk);
        start   <= 1'b1;
        vrender <= 9'(v);
        @(posedge clk);
        start   <= 1'b0;
        @(negedge clk);
        assert (done === 1'b0) else begin
            errors++;
            $display("done did not fall after a start edge, line %h", v);
        end
        while (done !== 1'b1) @(negedge clk);
    endtask

    task automatic read_line(input bit check);
        for (int i = 0; i <= `OBJ_LINE_W; i++) begin
            @(posedge clk);
            pix_addr <= 8'(i);
            @(negedge clk);
            if (check && i > 0) begin
                assert (pix === expect_pix[i-1]) else begin
                    errors++;
                    $display("[ERROR] pix at x %h: got %h, expected %h", i - 1, pix,
                             expect_pix[i-1]);
                end
            end
        end
    endtask

    initial begin
        int    fd;
        int    k;
        int    a;
        int    b;
        int    l_count;
        int    w_count;
        string line;
        l_count = 0;
        w_count = 0;
        foreach (expect_pix[i]) expect_pix[i] = 8'd0;
        fd = $fopen("obj_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open obj_tests.txt");
            $display("Verification failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    a = 0;
                    b = 0;
                    void'($sscanf(line, "%c %h %h", k, a, b));
                    rec_kind.push_back(k);
                    rec_a.push_back(a);
                    rec_b.push_back(b);
                    if (k == "L") l_count++;
                    if (k == "W") w_count++;
                end
            end
            $fclose(fd);
            limit = 20000 * l_count + 2 * (w_count + `OBJ_TABLE_SZ) + 1000;
            repeat (16) @(posedge clk);
            rst <= 1'b0;
            @(negedge clk);
            assert (done === 1'b1 && rom_cs === 1'b0) else begin
                errors++;
                $display("[ERROR] after reset done %h rom_cs %h, expected 1 and 0", done, rom_cs);
            end
            read_line(1'b0);  // empties the first display half
            // y byte at 240 keeps unused entries off the tested lines
            for (int i = 0; i < `OBJ_TABLE_SZ; i++) begin
                write_byte(i, (i % 5 == 2) ? 'hF0 : ((i & 'hFF) ^ ((i >> 1) & 'h80)));
            end
            foreach (rec_kind[r]) begin
                case (rec_kind[r])
                    "W": write_byte(rec_a[r], rec_b[r]);
                    "L": render_line(rec_a[r]);
                    "P": expect_pix[rec_a[r]] = 8'(rec_b[r]);
                    "E": begin
                        fork
                            render_line('h1FF);  // swap in the drawn line, draw nothing
                            begin
                                @(posedge clk);
                                read_line(1'b1);  // x 0 is read right after the swap
                            end
                        join
                        foreach (expect_pix[i]) expect_pix[i] = 8'd0;
                    end
                    default: begin
                        errors++;
                        $display("unknown record in obj_tests.txt, entry %0d", r);
                    end
                endcase
            end
            $display("errors: %0d", errors);
            if (errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* obj_video.sv */
`timescale 1ns/10ps
`default_nettype none

`include "obj_params.svh"

module obj_video import obj_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    input  wire cpu_wr_t            cpu,
    input  wire                     start,
    input  wire                     lvbl,
    input  wire [8:0]               vrender,
    output logic                    done,
    output logic                    rom_cs,
    output logic [`OBJ_ROM_AW-1:0]  rom_addr,
    input  wire                     rom_ok,
    input  wire [`OBJ_ROM_DW-1:0]   rom_data,
    input  wire [7:0]               pix_addr,
    output logic [7:0]              pix
);

    logic     last_start;
    logic     start_edge;  // swap and scan start together
    logic [8:0] scan_addr;
    logic [7:0] scan_data;
    line_wr_t line_wr;

    assign start_edge = start && !last_start && lvbl;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_start <= 1'b0;
        end else begin
            last_start <= start;
        end
    end

    obj_attr_ram attr_ram_inst (
        .clk       (clk),
        .cpu       (cpu),
        .scan_addr (scan_addr),
        .scan_data (scan_data)
    );

    obj_line_draw line_draw_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (start_edge),
        .lvbl      (lvbl),
        .vrender   (vrender),
        .done      (done),
        .scan_addr (scan_addr),
        .scan_data (scan_data),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_ok    (rom_ok),
        .rom_data  (rom_data),
        .line_wr   (line_wr)
    );

    obj_line_buf line_buf_inst (
        .clk      (clk),
        .rst      (rst),
        .swap     (start_edge),
        .line_wr  (line_wr),
        .pix_addr (pix_addr),
        .pix      (pix)
    );

endmodule

`default_nettype wire

/* obj_line_buf.sv */
`timescale 1ns/10ps
`default_nettype none

`include "obj_params.svh"

module obj_line_buf import obj_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire           swap,
    input  wire line_wr_t line_wr,
    input  wire [7:0]     pix_addr,
    output logic [7:0]    pix
);

    // both halves in one array, top address bit picks the half
    logic [7:0] mem [0:2*`OBJ_LINE_W-1];
    logic       sel;       // half being drawn
    logic       draw_we;
    logic [8:0] draw_idx;
    logic [8:0] disp_idx;

    assign draw_we  = line_wr.we
                    && (line_wr.addr < 9'(`OBJ_LINE_W))  // clip right edge
                    && (line_wr.din[3:0] != 4'd0);       // pixel 0 is transparent
    assign draw_idx = {sel, line_wr.addr[7:0]};
    assign disp_idx = {~sel, pix_addr};

    always_ff @(posedge clk) begin
        if (rst) begin
            sel <= 1'b0;
        end else if (swap) begin
            sel <= ~sel;
        end
    end

    // draw and display halves never collide
    always_ff @(posedge clk) begin
        if (draw_we) begin
            mem[draw_idx] <= line_wr.din;
        end
        pix           <= mem[disp_idx];
        mem[disp_idx] <= 8'd0;  // erase behind the beam
    end

endmodule

`default_nettype wire

/* obj_line_draw.sv */
`timescale 1ns/10ps
`default_nettype none

`include "obj_params.svh"

module obj_line_draw import obj_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start,      // already qualified edge
    input  wire                     lvbl,
    input  wire [8:0]               vrender,
    output logic                    done,
    output logic [8:0]              scan_addr,
    input  wire [7:0]               scan_data,
    output logic                    rom_cs,
    output logic [`OBJ_ROM_AW-1:0]  rom_addr,
    input  wire                     rom_ok,
    input  wire [`OBJ_ROM_DW-1:0]   rom_data,
    output line_wr_t                line_wr
);

    localparam logic [3:0] S_IDLE = 4'd0;
    localparam logic [3:0] S_B4   = 4'd1;   // address of byte 4 on the bus
    localparam logic [3:0] S_SIZE = 4'd2;
    localparam logic [3:0] S_Y    = 4'd3;
    localparam logic [3:0] S_CODE = 4'd4;
    localparam logic [3:0] S_PAL  = 4'd5;
    localparam logic [3:0] S_X    = 4'd6;
    localparam logic [3:0] S_ROM  = 4'd7;
    localparam logic [3:0] S_DUMP = 4'd8;
    localparam logic [3:0] S_STEP = 4'd9;
    localparam logic [3:0] S_NEXT = 4'd10;

    localparam logic [8:0] LAST_BASE = 9'((`OBJ_COUNT - 1) * `OBJ_STRIDE);

    logic [3:0]             st;
    obj_attr_t              obj;
    logic [8:0]             base;       // first byte of current entry
    logic [2:0]             byte_sel;
    logic [4:0]             vsub;       // line inside the sprite
    logic [2:0]             wcnt;       // 4-pixel group along x
    logic [1:0]             pcnt;
    logic [8:0]             xcnt;
    logic [`OBJ_ROM_DW-1:0] pxl;
    logic [5:0]             height;
    logic [2:0]             wlast;
    logic [3:0]             tile_off;
    logic [8:0]             upper;
    logic                   covers;

    assign scan_addr = base + 9'(byte_sel);
    assign rom_addr  = {obj.code + 14'(tile_off), vsub[2:0], wcnt[0]};

    always_comb begin
        case (obj.size)
            3'd1:    begin height = 6'd8;  wlast = 3'd3; end  // 16x8
            3'd2:    begin height = 6'd16; wlast = 3'd1; end  // 8x16
            3'd3:    begin height = 6'd8;  wlast = 3'd1; end  // 8x8
            3'd4:    begin height = 6'd32; wlast = 3'd7; end  // 32x32
            default: begin height = 6'd16; wlast = 3'd3; end  // 16x16
        endcase
        // 8x8 tiles laid out row by row inside the sprite
        case (wlast)
            3'd1:    tile_off = {2'b00, vsub[4:3]};
            3'd3:    tile_off = {1'b0, vsub[4:3], wcnt[1]};
            default: tile_off = {vsub[4:3], wcnt[2:1]};
        endcase
        upper  = {1'b0, scan_data} + {3'b000, height};  // ypos while in S_Y
        covers = (vrender >= {1'b0, scan_data}) && (vrender < upper);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st         <= S_IDLE;
            done       <= 1'b1;
            rom_cs     <= 1'b0;
            line_wr.we <= 1'b0;
        end else if (start) begin
            st         <= S_B4;
            done       <= 1'b0;
            rom_cs     <= 1'b0;
            line_wr.we <= 1'b0;
            base       <= 9'd0;
            byte_sel   <= 3'd4;
        end else begin
            line_wr.we <= 1'b0;
            case (st)
                S_IDLE: ;
                S_B4: begin
                    byte_sel <= 3'd2;
                    st       <= S_SIZE;
                end
                S_SIZE: begin
                    obj.attr        <= scan_data[5:0];
                    obj.size        <= scan_data[3:1];
                    obj.code[13:12] <= scan_data[7:6];
                    byte_sel        <= 3'd0;
                    st              <= S_Y;
                end
                S_Y: begin
                    obj.ypos <= scan_data;
                    vsub     <= 5'(vrender - {1'b0, scan_data});
                    byte_sel <= 3'd1;
                    st       <= covers ? S_CODE : S_NEXT;  // skip off-line sprites
                end
                S_CODE: begin
                    obj.code[9:2] <= scan_data;
                    byte_sel      <= 3'd3;
                    st            <= S_PAL;
                end
                S_PAL: begin
                    obj.code[11:10] <= scan_data[1:0];
                    obj.code[1:0]   <= scan_data[3:2];
                    obj.pal         <= scan_data[7:4];
                    st              <= S_X;
                end
                S_X: begin
                    obj.xpos <= scan_data;
                    xcnt     <= {1'b0, scan_data};
                    wcnt     <= 3'd0;
                    rom_cs   <= 1'b1;
                    st       <= S_ROM;
                end
                S_ROM: begin
                    if (rom_ok) begin  // hold here until the ROM answers
                        pxl    <= rom_data;
                        rom_cs <= 1'b0;
                        pcnt   <= 2'd0;
                        st     <= S_DUMP;
                    end
                end
                S_DUMP: begin
                    line_wr.we   <= 1'b1;
                    line_wr.addr <= xcnt;
                    line_wr.din  <= {obj.pal, pxl[`OBJ_ROM_DW-1 -: 4]};
                    pxl          <= pxl << 4;  // msb nibble goes first
                    xcnt         <= xcnt + 9'd1;
                    pcnt         <= pcnt + 2'd1;
                    if (pcnt == 2'd3) begin
                        st <= S_STEP;
                    end
                end
                S_STEP: begin
                    if (wcnt == wlast) begin
                        st <= S_NEXT;
                    end else begin
                        wcnt   <= wcnt + 3'd1;
                        rom_cs <= 1'b1;
                        st     <= S_ROM;
                    end
                end
                S_NEXT: begin
                    if (base == LAST_BASE) begin
                        done <= 1'b1;
                        st   <= S_IDLE;
                    end else begin
                        base     <= base + 9'(`OBJ_STRIDE);
                        byte_sel <= 3'd4;
                        st       <= S_B4;
                    end
                end
                default: st <= S_IDLE;
            endcase
        end
    end

    a_rom_cs_hold: assert property (
        @(posedge clk) disable iff (rst) $fell(rom_cs) |-> ($past(rom_ok) || $past(start))
    ) else $error("rom_cs dropped before rom_ok");

    a_no_write_when_done: assert property (
        @(posedge clk) disable iff (rst) !(line_wr.we && done)
    ) else $error("pixel write after scan end");

    // the top level only lets start through during active display
    a_start_in_active: assert property (
        @(posedge clk) disable iff (rst) start |-> lvbl
    ) else $error("scan started during blanking");

endmodule

`default_nettype wire

/* obj_attr_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "obj_params.svh"

module obj_attr_ram import obj_pkg::*; (
    input  wire          clk,
    input  wire cpu_wr_t cpu,
    input  wire [8:0]    scan_addr,
    output logic [7:0]   scan_data
);

    logic [7:0] mem [0:`OBJ_TABLE_SZ-1];  // 64 entries of 5 bytes

    // CPU side write port
    always_ff @(posedge clk) begin
        if (cpu.we) begin
            mem[cpu.addr] <= cpu.data;
        end
    end

    // renderer side, data one cycle after the address
    always_ff @(posedge clk) begin
        scan_data <= mem[scan_addr];
    end

    // the CPU must stay inside the table
    a_cpu_addr_range: assert property (
        @(posedge clk) cpu.we |-> (cpu.addr < 9'(`OBJ_TABLE_SZ))
    ) else $error("cpu write outside attribute table, addr %h", cpu.addr);

endmodule

`default_nettype wire

/* obj_pkg.sv */
`default_nettype none

package obj_pkg;

    // one byte write into the attribute table
    typedef struct packed {
        logic       we;    // write strobe
        logic [8:0] addr;  // byte address
        logic [7:0] data;
    } cpu_wr_t;

    // one pixel write into the draw buffer
    typedef struct packed {
        logic       we;    // write strobe
        logic [8:0] addr;  // x position, 256 and up is clipped
        logic [7:0] din;   // palette in 7:4, pixel in 3:0
    } line_wr_t;

    // one sprite, decoded from its five table bytes
    typedef struct packed {
        logic [13:0] code;
        logic [3:0]  pal;
        logic [2:0]  size;  // 0 16x16, 1 16x8, 2 8x16, 3 8x8, 4 32x32
        logic [7:0]  ypos;
        logic [7:0]  xpos;
        logic [5:0]  attr;  // low bits of byte 4
    } obj_attr_t;

endpackage

`default_nettype wire

/* obj_params.svh */
`ifndef OBJ_PARAMS_SVH
`define OBJ_PARAMS_SVH

// sprite attribute table
`define OBJ_COUNT     64
`define OBJ_STRIDE    5
`define OBJ_TABLE_SZ  320

// visible pixels per line, one line buffer half
`define OBJ_LINE_W    256

// graphics ROM, one word holds four 4-bit pixels
`define OBJ_ROM_AW    18
`define OBJ_ROM_DW    16

`endif
